/* verilog.f */
+incdir+verification
logic/crc_pkg.sv
logic/crc_engine.sv
logic/crc_frame_tracker.sv
logic/crc_compute.sv
logic/crc_check.sv
logic/crc_rx_top.sv
verification/crc_scoreboard.sv
verification/crc_tb.sv

/* run_sim.sh */
#!/bin/sh
# Compiles the CRC check testbench with Verilator and runs it
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal -f verilog.f --top-module crc_tb -o crc_sim

out=$(./obj_dir/crc_sim)
echo "$out"

if echo "$out" | grep -qx "ALL CHECKS PASSED"; then
   exit 0
fi
exit 1

/* verification/crc_ref.svh */
// Reference CRC for the testbench, MSB first with no reflection and no final XOR
// Included inside modules that import crc_pkg

// Folds the low nbits of data into a CRC of crc_w bits, crc_w up to 16
function automatic logic [15:0] crc_ref(input logic [15:0] crc, input logic [63:0] data,
                                        input int nbits, input int crc_w,
                                        input logic [15:0] poly);
   logic [15:0] c;
   c = crc;
   for (int b = nbits - 1; b >= 0; b--) begin
      if (c[crc_w-1] != data[b]) begin
         c = (c << 1) ^ poly;
      end else begin
         c = c << 1;
      end
   end
   // Bits above crc_w never feed back, so masking at the end is enough
   return c & ((16'd1 << crc_w) - 16'd1);
endfunction

/* verification/crc_tb.sv */
// Testbench for the receive CRC check
// Applies a table of frame tests to the DUT, the scoreboard compares the outputs

`timescale 1ns/1ps

module crc_tb
   import crc_pkg::*;
();

   `include "crc_ref.svh"

   localparam int NAME_W  = 96;
   localparam int N_TESTS = 8;

   typedef enum logic [2:0] {C_NONE, C_CRC01, C_CRC23, C_CRC45, C_CRCVW, C_DATA} corrupt_e;

   typedef struct packed {
      logic [NAME_W-1:0] name;
      int                frames;
      bit                gaps;
      corrupt_e          corrupt;
      int                bad_frame;
      bit                do_reset;
   } test_row_t;

   logic              clk;
   logic              rst_n;
   logic              tvalid;
   logic [DATA_W-1:0] tdata;
   logic              check_done;
   logic              crc_error;
   logic [NAME_W-1:0] test_name;
   int                err_cnt;
   int                done_cnt;
   int                cycle = 0;
   int                limit = 0;
   int                fails = 0;
   test_row_t         rows [N_TESTS];

   crc_rx_top crc_rx_top_i (
      .clk_i        (clk),
      .rst_n_i      (rst_n),
      .tvalid_i     (tvalid),
      .tdata_i      (tdata),
      .check_done_o (check_done),
      .crc_error_o  (crc_error)
   );

   crc_scoreboard #(.NAME_W(NAME_W)) crc_scoreboard_i (
      .clk_i        (clk),
      .rst_n_i      (rst_n),
      .tvalid_i     (tvalid),
      .tdata_i      (tdata),
      .check_done_i (check_done),
      .crc_error_i  (crc_error),
      .test_name_i  (test_name),
      .err_cnt_o    (err_cnt),
      .done_cnt_o   (done_cnt)
   );

   initial begin
      clk = 1'b0;
      forever #50 clk = ~clk;
   end

   always @(posedge clk) begin
      cycle <= cycle + 1;
      if (limit > 0 && cycle >= limit) begin
         $display("Timeout: the run did not finish within %0d cycles", limit);
         $display("CHECKS FAILED");
         $finish;
      end
   end

   // One word, behind 0 to 3 idle cycles in gap mode
   task automatic send_word(input logic [DATA_W-1:0] w, input bit gaps);
      int idle;
      idle = gaps ? int'($urandom % 4) : 0;
      repeat (idle) begin
         tvalid <= 1'b0;
         @(posedge clk);
      end
      tvalid <= 1'b1;
      tdata  <= w;
      @(posedge clk);
   endtask

   // Six random data words, then the validation word built from them
   task automatic send_frame(input corrupt_e kind, input bit gaps);
      logic [DATA_W-1:0] words [FRAME_DATA_WORDS];
      logic [15:0]       pc [3];
      logic [15:0]       vw;
      vd_pkt_t           vd;
      logic [DATA_W-1:0] vd_word;
      int                bsel;
      int                wsel;
      for (int i = 0; i < FRAME_DATA_WORDS; i++) begin
         words[i] = {$urandom, $urandom};
      end
      for (int p = 0; p < 3; p++) begin
         pc[p] = crc_ref(crc_ref(CRC16_INIT, words[2*p], DATA_W, CRC16_W, CRC16_POLY),
                         words[2*p+1], DATA_W, CRC16_W, CRC16_POLY);
      end
      vd.tag   = TAG_W'($urandom);
      vw       = crc_ref(16'(CRC8_INIT), 64'(vd.tag), TAG_W, CRC8_W, 16'(CRC8_POLY));
      vd.crcvw = vw[CRC8_W-1:0];
      vd.crc01 = pc[0];
      vd.crc23 = pc[1];
      vd.crc45 = pc[2];
      vd_word  = vd;
      // Flip position for a corrupted frame
      bsel = int'($urandom % DATA_W);
      wsel = int'($urandom % FRAME_DATA_WORDS);
      case (kind)
         C_CRC01: vd_word ^= DATA_W'(1) << (VD_CRC01_LSB + bsel % CRC16_W);
         C_CRC23: vd_word ^= DATA_W'(1) << (VD_CRC23_LSB + bsel % CRC16_W);
         C_CRC45: vd_word ^= DATA_W'(1) << (VD_CRC45_LSB + bsel % CRC16_W);
         C_CRCVW: vd_word ^= DATA_W'(1) << (VD_CRCVW_LSB + bsel % CRC8_W);
         C_DATA:  words[wsel] ^= DATA_W'(1) << bsel;
         default: ;
      endcase
      for (int i = 0; i < FRAME_DATA_WORDS; i++) begin
         send_word(words[i], gaps);
      end
      send_word(vd_word, gaps);
   endtask

   initial begin
      int start_err;
      int start_done;
      int start_fails;
      int bad;
      logic exp_err;
      rows = '{
         '{"clean_b2b",   4, 1'b0, C_NONE,  0, 1'b0},
         '{"bad_crc01",   3, 1'b0, C_CRC01, 0, 1'b1},
         '{"bad_crc23",   2, 1'b0, C_CRC23, 1, 1'b1},
         '{"bad_crc45",   2, 1'b1, C_CRC45, 0, 1'b1},
         '{"bad_crcvw",   2, 1'b0, C_CRCVW, 1, 1'b1},
         '{"bad_data",    2, 1'b1, C_DATA,  0, 1'b1},
         '{"reset_clean", 1, 1'b0, C_NONE,  0, 1'b1},
         '{"clean_gaps",  4, 1'b1, C_NONE,  0, 1'b0}
      };
      // Worst case of four cycles per word, plus margin
      foreach (rows[t]) begin
         limit += rows[t].frames * 7 * 4;
      end
      limit += 200;
      void'($urandom(27));
      exp_err   = 1'b0;
      rst_n     = 1'b0;
      tvalid    = 1'b0;
      tdata     = '0;
      test_name = '0;
      repeat (8) @(posedge clk);
      rst_n <= 1'b1;
      @(posedge clk);
      for (int t = 0; t < N_TESTS; t++) begin
         test_name <= rows[t].name;
         if (rows[t].do_reset) begin
            // Partial frame first, so the reset has a word count to clear
            repeat (3) send_word({$urandom, $urandom}, 1'b0);
            tvalid <= 1'b0;
            rst_n  <= 1'b0;
            repeat (8) @(posedge clk);
            rst_n <= 1'b1;
            @(posedge clk);
            exp_err = 1'b0;
         end
         start_err   = err_cnt;
         start_done  = done_cnt;
         start_fails = fails;
         for (int f = 0; f < rows[t].frames; f++) begin
            send_frame((f == rows[t].bad_frame) ? rows[t].corrupt : C_NONE, rows[t].gaps);
         end
         tvalid <= 1'b0;
         while (done_cnt - start_done < rows[t].frames) begin
            @(posedge clk);
         end
         repeat (3) @(posedge clk);
         if (rows[t].corrupt != C_NONE) begin
            exp_err = 1'b1;
         end
         if (done_cnt - start_done != rows[t].frames) begin
            $display("Mismatch %0s done count: expected %0d, actual %0d",
                     rows[t].name, rows[t].frames, done_cnt - start_done);
            fails++;
         end
         if (crc_error !== exp_err) begin
            $display("Mismatch %0s final crc_error_o: expected %0b, actual %0b",
                     rows[t].name, exp_err, crc_error);
            fails++;
         end
         bad = (err_cnt - start_err) + (fails - start_fails);
         $display("%s %0s: %0d frames, %0d errors", (bad == 0) ? "PASS" : "FAIL",
                  rows[t].name, rows[t].frames, bad);
      end
      $display("Tests %0d, done strobes %0d, errors %0d", N_TESTS, done_cnt, err_cnt + fails);
      if (err_cnt + fails == 0) begin
         $display("ALL CHECKS PASSED");
      end else begin
         $display("CHECKS FAILED");
      end
      $finish;
   end

endmodule

/* verification/crc_scoreboard.sv */
// Reference model and checker for the receive CRC check
// Rebuilds the CRCs from the observed stream and predicts each done strobe and the error flag

`timescale 1ns/1ps

module crc_scoreboard
   import crc_pkg::*;
#(
   parameter int NAME_W = 96
) (
   input  logic              clk_i,
   input  logic              rst_n_i,
   input  logic              tvalid_i,
   input  logic [DATA_W-1:0] tdata_i,
   input  logic              check_done_i,
   input  logic              crc_error_i,
   input  logic [NAME_W-1:0] test_name_i,
   output int                err_cnt_o,
   output int                done_cnt_o
);

   `include "crc_ref.svh"

   int           cyc = 0;
   int           wcnt = 0;
   int           err_cnt = 0;
   int           done_cnt = 0;
   logic [15:0]  run_crc;
   logic [15:0]  exp_pair [3];
   logic         err_model = 1'b0;
   int           due_q [$];
   bit           ok_q [$];

   function automatic bit fields_ok(input logic [DATA_W-1:0] w);
      vd_pkt_t     p;
      logic [15:0] vw;
      p  = w;
      vw = crc_ref(16'(CRC8_INIT), 64'(p.tag), TAG_W, CRC8_W, 16'(CRC8_POLY));
      return (p.crc01 == exp_pair[0]) && (p.crc23 == exp_pair[1]) &&
             (p.crc45 == exp_pair[2]) && (p.crcvw == vw[CRC8_W-1:0]);
   endfunction

   always @(posedge clk_i) begin
      cyc = cyc + 1;
      if (!rst_n_i) begin
         wcnt      = 0;
         err_model = 1'b0;
         due_q.delete();
         ok_q.delete();
      end else begin
         if (tvalid_i && wcnt < FRAME_DATA_WORDS) begin
            // Even word opens a pair from INIT, odd word closes it
            run_crc = crc_ref((wcnt % 2 == 0) ? CRC16_INIT : run_crc, tdata_i,
                              DATA_W, CRC16_W, CRC16_POLY);
            exp_pair[wcnt / 2] = run_crc;
            wcnt = wcnt + 1;
         end else if (tvalid_i) begin
            due_q.push_back(cyc + 3);
            ok_q.push_back(fields_ok(tdata_i));
            wcnt = 0;
         end
         if (check_done_i === 1'b1) begin
            done_cnt = done_cnt + 1;
         end
         if (due_q.size() > 0 && due_q[0] == cyc) begin
            if (check_done_i !== 1'b1) begin
               $display("%0s: check_done_o missing three cycles after a validation word",
                        test_name_i);
               err_cnt = err_cnt + 1;
            end
            err_model = err_model | !ok_q[0];
            void'(due_q.pop_front());
            void'(ok_q.pop_front());
         end else if (check_done_i !== 1'b0) begin
            $display("%0s: check_done_o pulsed with no validation word three cycles before",
                     test_name_i);
            err_cnt = err_cnt + 1;
         end
         if (crc_error_i !== err_model) begin
            $display("Mismatch %0s crc_error_o: expected %0b, actual %0b",
                     test_name_i, err_model, crc_error_i);
            err_cnt = err_cnt + 1;
         end
      end
      err_cnt_o  <= err_cnt;
      done_cnt_o <= done_cnt;
   end

endmodule

/* logic/crc_rx_top.sv */
// Receive-side CRC check of the serial link
// Frame tracker feeds the CRC compute stage, whose results go to the checker

`timescale 1ns/1ps

module crc_rx_top
   import crc_pkg::*;
(
   input  logic              clk_i,
   input  logic              rst_n_i,
   input  logic              tvalid_i,
   input  logic [DATA_W-1:0] tdata_i,
   output logic              check_done_o,
   output logic              crc_error_o
);

   logic               pair_start;
   logic               pair_end;
   logic [1:0]         pair_idx;
   logic               crc_boundary;
   logic [CRC16_W-1:0] crc01;
   logic [CRC16_W-1:0] crc23;
   logic [CRC16_W-1:0] crc45;
   logic [CRC8_W-1:0]  crcvw;
   logic               crc_valid;

   crc_frame_tracker crc_frame_tracker_i (
      .clk_i          (clk_i),
      .rst_n_i        (rst_n_i),
      .tvalid_i       (tvalid_i),
      .pair_start_o   (pair_start),
      .pair_end_o     (pair_end),
      .pair_idx_o     (pair_idx),
      .crc_boundary_o (crc_boundary)
   );

   crc_compute crc_compute_i (
      .clk_i          (clk_i),
      .rst_n_i        (rst_n_i),
      .tvalid_i       (tvalid_i),
      .tdata_i        (tdata_i),
      .pair_start_i   (pair_start),
      .pair_end_i     (pair_end),
      .pair_idx_i     (pair_idx),
      .crc_boundary_i (crc_boundary),
      .crc01_o        (crc01),
      .crc23_o        (crc23),
      .crc45_o        (crc45),
      .crcvw_o        (crcvw),
      .crc_valid_o    (crc_valid)
   );

   crc_check crc_check_i (
      .clk_i          (clk_i),
      .rst_n_i        (rst_n_i),
      .crc_boundary_i (crc_boundary),
      .tdata_i        (tdata_i),
      .crc01_i        (crc01),
      .crc23_i        (crc23),
      .crc45_i        (crc45),
      .crcvw_i        (crcvw),
      .crc_valid_i    (crc_valid),
      .check_done_o   (check_done_o),
      .crc_error_o    (crc_error_o)
   );

endmodule

/* logic/crc_check.sv */
// Captures each validation word and compares it with the computed CRCs
// Pulses check_done_o per frame and holds crc_error_o after the first mismatch

`timescale 1ns/1ps

module crc_check
   import crc_pkg::*;
(
   input  logic               clk_i,
   input  logic               rst_n_i,
   input  logic               crc_boundary_i,
   input  logic [DATA_W-1:0]  tdata_i,
   input  logic [CRC16_W-1:0] crc01_i,
   input  logic [CRC16_W-1:0] crc23_i,
   input  logic [CRC16_W-1:0] crc45_i,
   input  logic [CRC8_W-1:0]  crcvw_i,
   input  logic               crc_valid_i,
   output logic               check_done_o,
   output logic               crc_error_o
);

   vd_pkt_t vd_pkt;
   logic    match_q;
   logic    match_vld_q;
   logic    fields_match;

   // Validation word fields, held until the next boundary
   always_ff @(posedge clk_i) begin
      if (crc_boundary_i) begin
         vd_pkt.tag   <= tdata_i[VD_TAG_LSB   +: TAG_W];
         vd_pkt.crc01 <= tdata_i[VD_CRC01_LSB +: CRC16_W];
         vd_pkt.crc23 <= tdata_i[VD_CRC23_LSB +: CRC16_W];
         vd_pkt.crc45 <= tdata_i[VD_CRC45_LSB +: CRC16_W];
         vd_pkt.crcvw <= tdata_i[VD_CRCVW_LSB +: CRC8_W];
      end
   end

   assign fields_match = (vd_pkt.crc01 == crc01_i) &&
                         (vd_pkt.crc23 == crc23_i) &&
                         (vd_pkt.crc45 == crc45_i) &&
                         (vd_pkt.crcvw == crcvw_i);

   // First stage registers the compare result
   always_ff @(posedge clk_i) begin
      if (crc_valid_i) begin
         match_q <= fields_match;
      end
   end

   // Second stage raises done and the sticky error together
   always_ff @(posedge clk_i) begin
      if (!rst_n_i) begin
         match_vld_q  <= 1'b0;
         check_done_o <= 1'b0;
         crc_error_o  <= 1'b0;
      end else begin
         match_vld_q  <= crc_valid_i;
         check_done_o <= match_vld_q;
         crc_error_o  <= crc_error_o | (match_vld_q & ~match_q);
      end
   end

   // Boundary, then valid, then done two cycles later
   property p_done_delay;
      @(posedge clk_i) disable iff (!rst_n_i)
         crc_boundary_i |-> ##1 crc_valid_i ##2 check_done_o;
   endproperty

   p_done_delay_A :
   assert property (p_done_delay)
   else $error("check_done_o late or missing at %m");

   // Every done traces back to a valid and a boundary
   property p_no_spurious_done;
      @(posedge clk_i) disable iff (!rst_n_i)
         check_done_o |-> $past(crc_valid_i, 2) && $past(crc_boundary_i, 3);
   endproperty

   p_no_spurious_done_A :
   assert property (p_no_spurious_done)
   else $error("check_done_o without a preceding check at %m");

   p_error_with_done_A :
   assert property (@(posedge clk_i) disable iff (!rst_n_i)
                    $rose(crc_error_o) |-> check_done_o)
   else $error("crc_error_o rose outside a check_done_o at %m");

   p_error_sticky_A :
   assert property (@(posedge clk_i) disable iff (!rst_n_i)
                    crc_error_o |=> crc_error_o)
   else $error("crc_error_o dropped before reset at %m");

   cover_done_C :
   cover property (@(posedge clk_i) disable iff (!rst_n_i) check_done_o);

   cover_error_C :
   cover property (@(posedge clk_i) disable iff (!rst_n_i) crc_error_o);

endmodule

/* logic/crc_compute.sv */
// Computes the three pair CRC-16 values and the tag CRC-8 of each frame
// Results are stable when crc_valid_o pulses, one cycle after the boundary word

`timescale 1ns/1ps

module crc_compute
   import crc_pkg::*;
(
   input  logic               clk_i,
   input  logic               rst_n_i,
   input  logic               tvalid_i,
   input  logic [DATA_W-1:0]  tdata_i,
   input  logic               pair_start_i,
   input  logic               pair_end_i,
   input  logic [1:0]         pair_idx_i,
   input  logic               crc_boundary_i,
   output logic [CRC16_W-1:0] crc01_o,
   output logic [CRC16_W-1:0] crc23_o,
   output logic [CRC16_W-1:0] crc45_o,
   output logic [CRC8_W-1:0]  crcvw_o,
   output logic               crc_valid_o
);

   logic               pair_en;
   logic               pair_restart;
   logic               tag_en;
   logic [CRC16_W-1:0] pair_crc;
   logic               pair_end_q;
   logic [1:0]         pair_idx_q;

   assign pair_en      = tvalid_i & (pair_start_i | pair_end_i);
   assign pair_restart = tvalid_i & pair_start_i;
   assign tag_en       = tvalid_i & crc_boundary_i;

   // One engine shared by all three data pairs
   crc_engine #(
      .payload_t (logic [DATA_W-1:0]),
      .CRC_W     (CRC16_W),
      .POLY      (CRC16_POLY),
      .INIT      (CRC16_INIT)
   ) pair_crc_i (
      .clk_i     (clk_i),
      .rst_n_i   (rst_n_i),
      .en_i      (pair_en),
      .restart_i (pair_restart),
      .data_i    (tdata_i),
      .crc_o     (pair_crc)
   );

   // Tag CRC, always a fresh start on the validation word
   crc_engine #(
      .payload_t (logic [TAG_W-1:0]),
      .CRC_W     (CRC8_W),
      .POLY      (CRC8_POLY),
      .INIT      (CRC8_INIT)
   ) tag_crc_i (
      .clk_i     (clk_i),
      .rst_n_i   (rst_n_i),
      .en_i      (tag_en),
      .restart_i (tag_en),
      .data_i    (tdata_i[VD_TAG_LSB +: TAG_W]),
      .crc_o     (crcvw_o)
   );

   always_ff @(posedge clk_i) begin
      if (!rst_n_i) begin
         pair_end_q  <= 1'b0;
         crc_valid_o <= 1'b0;
      end else begin
         pair_end_q  <= pair_end_i & tvalid_i;
         crc_valid_o <= crc_boundary_i;
      end
   end

   // Engine output is final the cycle after the pair's second word
   always_ff @(posedge clk_i) begin
      pair_idx_q <= pair_idx_i;
      if (pair_end_q) begin
         case (pair_idx_q)
            2'd0:    crc01_o <= pair_crc;
            2'd1:    crc23_o <= pair_crc;
            2'd2:    crc45_o <= pair_crc;
            default: ;
         endcase
      end
   end

   // No pair result may still be waiting for its slot when the results are presented
   valid_after_boundary_A :
   assert property (@(posedge clk_i) disable iff (!rst_n_i)
                    crc_valid_o |-> $past(crc_boundary_i) && !pair_end_q)
   else $error("crc_valid_o without a boundary or with a pair result pending at %m");

endmodule

/* logic/crc_frame_tracker.sv */
// Word counter for the incoming stream
// Decodes data-pair markers and the validation word boundary from the count

`timescale 1ns/1ps

module crc_frame_tracker
   import crc_pkg::*;
(
   input  logic       clk_i,
   input  logic       rst_n_i,
   input  logic       tvalid_i,
   output logic       pair_start_o,
   output logic       pair_end_o,
   output logic [1:0] pair_idx_o,
   output logic       crc_boundary_o
);

   logic [WCNT_W-1:0] word_cnt;
   logic              is_data;
   logic              is_vd;

   // Positions 0 to 5 are data, position 6 is the validation word
   assign is_data = (word_cnt < WCNT_W'(FRAME_DATA_WORDS));
   assign is_vd   = (word_cnt == WCNT_W'(FRAME_DATA_WORDS));

   always_ff @(posedge clk_i) begin
      if (!rst_n_i) begin
         word_cnt <= '0;
      end else if (tvalid_i) begin
         if (is_vd) begin
            word_cnt <= '0;
         end else begin
            word_cnt <= word_cnt + 1'b1;
         end
      end
   end

   // Even positions open a pair, odd positions close it
   assign pair_start_o   = tvalid_i & is_data & ~word_cnt[0];
   assign pair_end_o     = tvalid_i & is_data & word_cnt[0];
   assign pair_idx_o     = word_cnt[WCNT_W-1:1];

   // Same cycle as the validation word itself
   assign crc_boundary_o = tvalid_i & is_vd;

   cnt_in_range_A :
   assert property (@(posedge clk_i) disable iff (!rst_n_i)
                    word_cnt <= WCNT_W'(FRAME_DATA_WORDS))
   else $error("Word counter out of range at %m");

endmodule

/* logic/crc_engine.sv */
// Registered CRC update engine, one payload folded per enabled cycle
// The payload type sets how many bits are folded, MSB first

`timescale 1ns/1ps

module crc_engine
   import crc_pkg::*;
#(
   parameter type              payload_t = logic [DATA_W-1:0],
   parameter int               CRC_W     = CRC16_W,
   parameter logic [CRC_W-1:0] POLY      = CRC16_POLY,
   parameter logic [CRC_W-1:0] INIT      = CRC16_INIT
) (
   input  logic             clk_i,
   input  logic             rst_n_i,
   input  logic             en_i,
   input  logic             restart_i,
   input  payload_t         data_i,
   output logic [CRC_W-1:0] crc_o
);

   localparam int PW = $bits(payload_t);

   // Bit-serial LFSR unrolled across the whole payload
   function automatic logic [CRC_W-1:0] crc_fold(input logic [CRC_W-1:0] crc_in,
                                                input logic [PW-1:0]    data);
      logic [CRC_W-1:0] c;
      logic             fb;
      c = crc_in;
      for (int i = PW - 1; i >= 0; i--) begin
         fb = c[CRC_W-1] ^ data[i];
         c  = {c[CRC_W-2:0], 1'b0};
         if (fb) begin
            c = c ^ POLY;
         end
      end
      return c;
   endfunction

   logic [CRC_W-1:0] seed;

   // A restart folds the payload into INIT instead of the running value
   assign seed = restart_i ? INIT : crc_o;

   always_ff @(posedge clk_i) begin
      if (!rst_n_i) begin
         crc_o <= INIT;
      end else if (en_i) begin
         crc_o <= crc_fold(seed, data_i);
      end
   end

   restart_needs_en_A :
   assert property (@(posedge clk_i) disable iff (!rst_n_i) restart_i |-> en_i)
   else $error("restart_i without en_i at %m");

endmodule

/* logic/crc_pkg.sv */
// Shared widths, CRC polynomials and validation packet layout for the receive CRC check
// Imported by wildcard in every RTL module header

package crc_pkg;

   // Stream word
   localparam int DATA_W = 64;

   // Pair CRC-16, MSB first, no reflection, no final XOR
   localparam int               CRC16_W    = 16;
   localparam logic [16-1:0]    CRC16_POLY = 16'h1021;
   localparam logic [16-1:0]    CRC16_INIT = 16'hFFFF;

   // Tag CRC-8
   localparam int               CRC8_W     = 8;
   localparam logic [8-1:0]     CRC8_POLY  = 8'h07;
   localparam logic [8-1:0]     CRC8_INIT  = 8'h00;

   // Validation tag
   localparam int TAG_W = 8;

   // Six data words, then one validation word
   localparam int FRAME_DATA_WORDS = 6;

   // Word counter runs 0 to FRAME_DATA_WORDS
   localparam int WCNT_W = $clog2(FRAME_DATA_WORDS + 1);

   // Field positions inside the validation word
   localparam int VD_TAG_LSB   = 0;
   localparam int VD_CRC01_LSB = 8;
   localparam int VD_CRC23_LSB = 24;
   localparam int VD_CRC45_LSB = 40;
   localparam int VD_CRCVW_LSB = 56;

   // Validation word, most significant field first
   typedef struct packed {
      logic [CRC8_W-1:0]  crcvw;
      logic [CRC16_W-1:0] crc45;
      logic [CRC16_W-1:0] crc23;
      logic [CRC16_W-1:0] crc01;
      logic [TAG_W-1:0]   tag;
   } vd_pkt_t;

endpackage
